//--- all.f
+incdir+include
design/rvPkg.sv
design/instDecoder.sv
design/controller.sv
design/regFile.sv
design/alu.sv
design/pcUnit.sv
design/processorSc.sv
bench/processorScTb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/100ps
TOP       = processorScTb
FILELIST  = all.f
OBJDIR    = obj_dir
LOG       = sim.log
PASS_MSG  = Test OK

SRCS := $(shell grep -v '^+' $(FILELIST)) include/rvDefs_defs.svh

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- bench/processorScTb.sv
// Program comes only from the row table; data memory is 64 words and wraps every 256 bytes
`include "rvDefs_defs.svh"

module processorScTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          ClkPeriod   = 8;
    localparam int          ResetCycles = 4;
    localparam int          NumRows     = 51;
    localparam logic [31:0] Nop         = 32'h0000_0013;   // ADDI x0, x0, 0
    localparam logic [6:0]  OpImm       = 7'b0010011;
    localparam logic [6:0]  OpLoad      = 7'b0000011;
    localparam logic [6:0]  OpJalr      = 7'b1100111;

    typedef struct packed {
        logic [31:0] pc;        // Expected o_pgmAddr
        logic [31:0] inst;
        logic        wr;        // SW row
        logic [31:0] addr;      // Expected store address
        logic [31:0] data;      // Store data, or the load address when fromMem
        logic        fromMem;
    } rowT;

    logic                clock;
    logic                arstN;
    logic [`RV_XLEN-1:0] pgmAddr;
    logic [31:0]         pgmInst;
    logic [`RV_XLEN-1:0] memAddr;
    logic                memWrEnable;
    logic [`RV_XLEN-1:0] memWrData;
    logic [`RV_XLEN-1:0] memRdData;

    rowT                 prog [NumRows];
    int                  rowCount;
    int                  errors;
    int                  checks;
    integer              seed;
    logic [31:0]         dataMem [0:63];

    processorSc u_dut (
        .i_Clock       (clock),
        .i_arstN       (arstN),
        .o_pgmAddr     (pgmAddr),
        .i_pgmInst     (pgmInst),
        .o_memAddr     (memAddr),
        .o_memWrEnable (memWrEnable),
        .o_memWrData   (memWrData),
        .i_memRdData   (memRdData)
    );

    always #(ClkPeriod / 2) clock = ~clock;

    // Data memory, combinational read
    assign memRdData = dataMem[memAddr[7:2]];

    initial begin : memoryModel
        seed = 32'h4565_e9dd;
        for (int k = 0; k < 64; k++) begin
            dataMem[k] <= $random(seed);            // Random fill
        end
        forever begin
            @(posedge clock);
            if (memWrEnable) dataMem[memAddr[7:2]] <= memWrData;   // SW lands at the edge
        end
    end

    // Encoders in base ISA field order
    function automatic logic [31:0] rFormat(input logic [6:0] f7, input logic [2:0] f3,
                                            input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] iFormat(input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [4:0] rs1, input logic [31:0] imm,
                                            input logic [6:0] opcode);
        return {imm[11:0], rs1, f3, rd, opcode};
    endfunction

    function automatic logic [31:0] sFormat(input logic [4:0] rs2, input logic [4:0] rs1,
                                            input logic [31:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};   // SW only
    endfunction

    function automatic logic [31:0] bFormat(input logic [2:0] f3, input logic [4:0] rs1,
                                            input logic [4:0] rs2, input logic [31:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] uFormat(input logic [4:0] rd, input logic [19:0] upper);
        return {upper, rd, 7'b0110111};             // LUI
    endfunction

    function automatic logic [31:0] jFormat(input logic [4:0] rd, input logic [31:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic quietRow(input logic [31:0] pc, input logic [31:0] inst);
        prog[rowCount] = '{pc: pc, inst: inst, default: '0};    // No store expected
        rowCount++;
    endtask

    task automatic storeRow(input logic [31:0] pc, input logic [31:0] inst,
                            input logic [31:0] addr, input logic [31:0] data,
                            input logic fromMem);
        prog[rowCount] = '{pc, inst, 1'b1, addr, data, fromMem};
        rowCount++;
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // Rows in execution order; x1 = 5 and x2 = -3 feed most results
    task automatic buildProgram();
        quietRow(32'h00, iFormat(3'b000, 5'd1, 5'd0, 32'd5, OpImm));           // ADDI
        quietRow(32'h04, iFormat(3'b000, 5'd2, 5'd0, 32'hFFFF_FFFD, OpImm));   // -3
        storeRow(32'h08, sFormat(5'd2, 5'd0, 32'h00), 32'h00, 32'hFFFF_FFFD, 1'b0);
        quietRow(32'h0C, rFormat(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));            // ADD
        storeRow(32'h10, sFormat(5'd3, 5'd0, 32'h04), 32'h04, 32'h2, 1'b0);
        quietRow(32'h14, rFormat(7'h20, 3'b000, 5'd4, 5'd1, 5'd2));            // SUB
        storeRow(32'h18, sFormat(5'd4, 5'd0, 32'h08), 32'h08, 32'h8, 1'b0);
        quietRow(32'h1C, rFormat(7'h00, 3'b010, 5'd5, 5'd2, 5'd1));            // SLT -3 < 5
        quietRow(32'h20, rFormat(7'h00, 3'b011, 5'd6, 5'd2, 5'd1));            // SLTU, false
        storeRow(32'h24, sFormat(5'd5, 5'd0, 32'h0C), 32'h0C, 32'h1, 1'b0);
        storeRow(32'h28, sFormat(5'd6, 5'd0, 32'h10), 32'h10, 32'h0, 1'b0);
        quietRow(32'h2C, rFormat(7'h00, 3'b111, 5'd7, 5'd1, 5'd2));            // AND
        quietRow(32'h30, rFormat(7'h00, 3'b110, 5'd8, 5'd1, 5'd2));            // OR
        quietRow(32'h34, rFormat(7'h00, 3'b100, 5'd9, 5'd1, 5'd2));            // XOR
        storeRow(32'h38, sFormat(5'd7, 5'd0, 32'h14), 32'h14, 32'h5, 1'b0);
        storeRow(32'h3C, sFormat(5'd8, 5'd0, 32'h18), 32'h18, 32'hFFFF_FFFD, 1'b0);
        storeRow(32'h40, sFormat(5'd9, 5'd0, 32'h1C), 32'h1C, 32'hFFFF_FFF8, 1'b0);
        quietRow(32'h44, iFormat(3'b111, 5'd10, 5'd2, 32'h0F0, OpImm));        // ANDI
        quietRow(32'h48, iFormat(3'b110, 5'd11, 5'd1, 32'hFFFF_FFF0, OpImm));  // ORI -16
        quietRow(32'h4C, iFormat(3'b100, 5'd12, 5'd2, 32'h7FF, OpImm));        // XORI
        quietRow(32'h50, iFormat(3'b010, 5'd13, 5'd2, 32'h1, OpImm));          // SLTI
        quietRow(32'h54, iFormat(3'b011, 5'd14, 5'd2, 32'h1, OpImm));          // SLTIU
        storeRow(32'h58, sFormat(5'd10, 5'd0, 32'h20), 32'h20, 32'h0F0, 1'b0);
        storeRow(32'h5C, sFormat(5'd11, 5'd0, 32'h24), 32'h24, 32'hFFFF_FFF5, 1'b0);
        storeRow(32'h60, sFormat(5'd12, 5'd0, 32'h28), 32'h28, 32'hFFFF_F802, 1'b0);
        storeRow(32'h64, sFormat(5'd13, 5'd0, 32'h2C), 32'h2C, 32'h1, 1'b0);
        storeRow(32'h68, sFormat(5'd14, 5'd0, 32'h30), 32'h30, 32'h0, 1'b0);
        quietRow(32'h6C, uFormat(5'd16, 20'hABCDE));
        storeRow(32'h70, sFormat(5'd16, 5'd0, 32'h34), 32'h34, 32'hABCD_E000, 1'b0);
        quietRow(32'h74, iFormat(3'b000, 5'd0, 5'd1, 32'd7, OpImm));           // x0 stays 0
        storeRow(32'h78, sFormat(5'd0, 5'd0, 32'h38), 32'h38, 32'h0, 1'b0);
        quietRow(32'h7C, iFormat(3'b000, 5'd17, 5'd0, 32'h0F0, OpImm));
        quietRow(32'h80, iFormat(3'b010, 5'd18, 5'd17, 32'h8, OpLoad));        // LW from 0xF8
        storeRow(32'h84, sFormat(5'd18, 5'd17, 32'hFFFF_FFFC), 32'hEC, 32'hF8, 1'b1);
        quietRow(32'h88, bFormat(3'b000, 5'd1, 5'd1, 32'h8));    // BEQ taken
        quietRow(32'h90, bFormat(3'b000, 5'd1, 5'd2, 32'h8));    // BEQ not taken
        quietRow(32'h94, bFormat(3'b001, 5'd1, 5'd2, 32'h8));    // BNE taken
        quietRow(32'h9C, bFormat(3'b001, 5'd3, 5'd3, 32'h8));
        quietRow(32'hA0, bFormat(3'b100, 5'd2, 5'd1, 32'h8));    // BLT, -3 < 5
        quietRow(32'hA8, bFormat(3'b100, 5'd1, 5'd2, 32'h8));
        quietRow(32'hAC, bFormat(3'b101, 5'd1, 5'd2, 32'h8));    // BGE taken
        quietRow(32'hB4, bFormat(3'b101, 5'd2, 5'd1, 32'h8));
        quietRow(32'hB8, bFormat(3'b110, 5'd1, 5'd2, 32'h8));    // BLTU, 5 < 0xFFFFFFFD
        quietRow(32'hC0, bFormat(3'b110, 5'd2, 5'd1, 32'h8));
        quietRow(32'hC4, bFormat(3'b111, 5'd2, 5'd1, 32'h8));    // BGEU taken
        quietRow(32'hCC, bFormat(3'b111, 5'd3, 5'd1, 32'h8));    // 2 >= 5 false
        quietRow(32'hD0, jFormat(5'd19, 32'h10));                // JAL to 0xE0
        storeRow(32'hE0, sFormat(5'd19, 5'd0, 32'h3C), 32'h3C, 32'hD4, 1'b0);
        quietRow(32'hE4, iFormat(3'b000, 5'd20, 5'd0, 32'h105, OpImm));
        quietRow(32'hE8, iFormat(3'b000, 5'd21, 5'd20, 32'hFFFF_FFFC, OpJalr)); // 0x101 -> 0x100
        storeRow(32'h100, sFormat(5'd21, 5'd0, 32'h40), 32'h40, 32'hEC, 1'b0);
    endtask

    initial begin : mainSequence
        logic [31:0] expData;
        clock    = 1'b0;
        arstN    = 1'b0;
        pgmInst  = Nop;                             // NOP while in reset
        rowCount = 0;
        errors   = 0;
        checks   = 0;
        buildProgram();
        if (rowCount != NumRows) begin
            errors++;
            $display("Program table holds %0d rows but %0d were planned", rowCount, NumRows);
        end
        repeat (ResetCycles) begin
            @(posedge clock);
            #1;
            checkValue("o_pgmAddr", pgmAddr, 32'h0);
            checkValue("o_memWrEnable", 32'(memWrEnable), 32'h0);
        end
        arstN = 1'b1;                               // 1 ns after the edge
        for (int r = 0; r < NumRows; r++) begin
            checkValue("o_pgmAddr", pgmAddr, prog[r].pc);
            pgmInst = prog[r].inst;
            #3;                                     // Mid cycle, outputs settled
            checkValue("o_memWrEnable", 32'(memWrEnable), 32'(prog[r].wr));
            if (prog[r].wr) begin
                checkValue("o_memAddr", memAddr, prog[r].addr);
                expData = prog[r].fromMem ? dataMem[prog[r].data[7:2]] : prog[r].data;
                checkValue("o_memWrData", memWrData, expData);
            end
            @(posedge clock);
            #1;
        end
        pgmInst = Nop;
        $display("Run done, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Table length plus reset plus margin
    initial begin : watchdog
        #((NumRows + ResetCycles + 10) * ClkPeriod);
        $display("Run timed out before the program table was finished");
        $display("Test FAILED");
        $finish;
    end

endmodule

//--- design/processorSc.sv
// Single-cycle RV32I subset core; program and data reads must return in the same cycle
`include "rvDefs_defs.svh"

module processorSc (
    input  logic                   i_Clock,
    input  logic                   i_arstN,        // Async reset, active low

    output logic [`RV_XLEN-1:0]    o_pgmAddr,      // Instruction address
    input  rvPkg::instU            i_pgmInst,      // Instruction, same cycle

    output logic [`RV_XLEN-1:0]    o_memAddr,      // Data address
    output logic                   o_memWrEnable,  // Write at next rising edge
    output logic [`RV_XLEN-1:0]    o_memWrData,    // Store data
    input  logic [`RV_XLEN-1:0]    i_memRdData     // Load data, combinational
);

    logic [`RV_REG_AW-1:0] rs1;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0]   imm;
    logic [`RV_XLEN-1:0]   rs1Data;
    logic [`RV_XLEN-1:0]   rs2Data;
    rvPkg::aluOpE          aluOp;
    logic                  opBSel;
    rvPkg::wbSelE          wbSel;
    logic                  regWrEnable;
    logic                  memWrEnable;
    rvPkg::pcSelE          pcSel;
    logic [`RV_XLEN-1:0]   operandB;       // ALU input B
    logic [`RV_XLEN-1:0]   aluResult;
    logic [`RV_XLEN-1:0]   wbData;         // Register write value
    logic [`RV_XLEN-1:0]   pc;
    logic [`RV_XLEN-1:0]   pcPlus4;

    instDecoder u_decoder (
        .i_inst (i_pgmInst),
        .o_rs1  (rs1),
        .o_rs2  (rs2),
        .o_rd   (rd),
        .o_imm  (imm)
    );

    controller u_ctrl (
        .i_inst        (i_pgmInst),
        .i_rs1Data     (rs1Data),
        .i_rs2Data     (rs2Data),
        .o_aluOp       (aluOp),
        .o_opBSel      (opBSel),
        .o_wbSel       (wbSel),
        .o_regWrEnable (regWrEnable),
        .o_memWrEnable (memWrEnable),
        .o_pcSel       (pcSel)
    );

    regFile u_regs (
        .i_Clock    (i_Clock),
        .i_arstN    (i_arstN),
        .i_wrAddr   (rd),
        .i_wrData   (wbData),
        .i_wrEnable (regWrEnable),
        .i_rdAddrA  (rs1),
        .o_rdDataA  (rs1Data),
        .i_rdAddrB  (rs2),
        .o_rdDataB  (rs2Data)
    );

    // Operand B, register or immediate
    assign operandB = opBSel ? imm : rs2Data;

    alu u_alu (
        .i_op       (aluOp),
        .i_operandA (rs1Data),
        .i_operandB (operandB),
        .o_result   (aluResult)
    );

    // Writeback source
    always_comb begin
        case (wbSel)
            rvPkg::WbMem:     wbData = i_memRdData;    // LW
            rvPkg::WbPcPlus4: wbData = pcPlus4;        // JAL/JALR link
            default:          wbData = aluResult;
        endcase
    end

    pcUnit u_pc (
        .i_Clock   (i_Clock),
        .i_arstN   (i_arstN),
        .i_pcSel   (pcSel),
        .i_imm     (imm),
        .i_rs1Data (rs1Data),
        .o_pc      (pc),
        .o_pcPlus4 (pcPlus4)
    );

    // External ports
    assign o_pgmAddr     = pc;
    assign o_memAddr     = aluResult;      // rs1+imm for LW/SW
    assign o_memWrEnable = memWrEnable;
    assign o_memWrData   = rs2Data;

endmodule

//--- design/pcUnit.sv
// PC register and next-PC adders; no alignment check on branch or JAL targets
`include "rvDefs_defs.svh"

module pcUnit (
    input  logic                   i_Clock,
    input  logic                   i_arstN,        // Holds PC at reset value
    input  rvPkg::pcSelE           i_pcSel,        // Next PC choice
    input  logic [`RV_XLEN-1:0]    i_imm,          // Branch/jump offset
    input  logic [`RV_XLEN-1:0]    i_rs1Data,      // JALR base
    output logic [`RV_XLEN-1:0]    o_pc,           // Current PC
    output logic [`RV_XLEN-1:0]    o_pcPlus4       // Sequential PC, also link value
);

    localparam logic [`RV_XLEN-1:0] PcStep = `RV_WORD_BYTES;

    logic [`RV_XLEN-1:0] pcPlusImm;    // Branch and JAL target
    logic [`RV_XLEN-1:0] rs1PlusImm;   // JALR sum
    logic [`RV_XLEN-1:0] pcNext;

    assign o_pcPlus4  = o_pc + PcStep;
    assign pcPlusImm  = o_pc + i_imm;
    assign rs1PlusImm = i_rs1Data + i_imm;

    always_comb begin
        case (i_pcSel)
            rvPkg::PcRel:  pcNext = pcPlusImm;
            rvPkg::PcJalr: pcNext = {rs1PlusImm[`RV_XLEN-1:1], 1'b0};  // Bit 0 cleared
            default:       pcNext = o_pcPlus4;
        endcase
    end

    // Loads every cycle, no stall
    always_ff @(posedge i_Clock or negedge i_arstN) begin
        if (!i_arstN) begin
            o_pc <= `RV_RESET_PC;
        end else begin
            o_pc <= pcNext;
        end
    end

endmodule

//--- design/alu.sv
// Integer ALU for the kept operations; no shifter and no flags
`include "rvDefs_defs.svh"

module alu (
    input  rvPkg::aluOpE           i_op,           // Function select
    input  logic [`RV_XLEN-1:0]    i_operandA,     // rs1 data
    input  logic [`RV_XLEN-1:0]    i_operandB,     // rs2 data or immediate
    output logic [`RV_XLEN-1:0]    o_result
);

    logic ltSigned;
    logic ltUnsigned;

    // Set-less-than compares
    assign ltSigned   = ($signed(i_operandA) < $signed(i_operandB));
    assign ltUnsigned = (i_operandA < i_operandB);

    always_comb begin
        case (i_op)
            rvPkg::AluAdd:   o_result = i_operandA + i_operandB;   // Also address calc
            rvPkg::AluSub:   o_result = i_operandA - i_operandB;
            rvPkg::AluAnd:   o_result = i_operandA & i_operandB;
            rvPkg::AluOr:    o_result = i_operandA | i_operandB;
            rvPkg::AluXor:   o_result = i_operandA ^ i_operandB;
            rvPkg::AluSlt: begin
                o_result = {{(`RV_XLEN-1){1'b0}}, ltSigned};
            end
            rvPkg::AluSltu: begin
                o_result = {{(`RV_XLEN-1){1'b0}}, ltUnsigned};
            end
            rvPkg::AluPassB: o_result = i_operandB;                 // LUI
            default:         o_result = '0;
        endcase
    end

endmodule

//--- design/regFile.sv
// Two async read ports, one write port; x0 reads zero and no write bypass exists
`include "rvDefs_defs.svh"

module regFile (
    input  logic                    i_Clock,
    input  logic                    i_arstN,        // Clears all registers
    input  logic [`RV_REG_AW-1:0]   i_wrAddr,       // Write address
    input  logic [`RV_XLEN-1:0]     i_wrData,       // Write data
    input  logic                    i_wrEnable,     // Write strobe
    input  logic [`RV_REG_AW-1:0]   i_rdAddrA,      // Read address A
    output logic [`RV_XLEN-1:0]     o_rdDataA,      // Read data A
    input  logic [`RV_REG_AW-1:0]   i_rdAddrB,      // Read address B
    output logic [`RV_XLEN-1:0]     o_rdDataB       // Read data B
);

    // x1..x31, x0 has no storage
    logic [`RV_XLEN-1:0] regs [1:(1 << `RV_REG_AW)-1];

    always_ff @(posedge i_Clock or negedge i_arstN) begin
        if (!i_arstN) begin
            for (int idx = 1; idx < (1 << `RV_REG_AW); idx++) begin
                regs[idx] <= '0;
            end
        end else if (i_wrEnable && i_wrAddr != '0) begin   // Writes to x0 dropped
            regs[i_wrAddr] <= i_wrData;
        end
    end

    // Combinational reads
    assign o_rdDataA = (i_rdAddrA == '0) ? '0 : regs[i_rdAddrA];
    assign o_rdDataB = (i_rdAddrB == '0) ? '0 : regs[i_rdAddrB];

endmodule

//--- design/controller.sv
// Control decode for the kept subset; shifts and unknown opcodes run as a NOP with PC+4
`include "rvDefs_defs.svh"

module controller (
    input  rvPkg::instU            i_inst,          // Current instruction
    input  logic [`RV_XLEN-1:0]    i_rs1Data,       // rs1 value, branch compare
    input  logic [`RV_XLEN-1:0]    i_rs2Data,       // rs2 value, branch compare
    output rvPkg::aluOpE           o_aluOp,         // ALU function
    output logic                   o_opBSel,        // 1 selects the immediate
    output rvPkg::wbSelE           o_wbSel,         // Writeback source
    output logic                   o_regWrEnable,   // Register write
    output logic                   o_memWrEnable,   // Data memory write
    output rvPkg::pcSelE           o_pcSel          // Next PC choice
);

    logic [2:0]   funct3;
    logic [6:0]   funct7;
    rvPkg::aluOpE arithOp;      // ALU op from funct3/funct7
    logic         arithValid;   // Function code is a kept one
    logic         isEq;
    logic         isLtS;
    logic         isLtU;
    logic         brTaken;

    assign funct3 = i_inst.r.funct3;
    assign funct7 = i_inst.r.funct7;

    // Register compares for branches
    assign isEq  = (i_rs1Data == i_rs2Data);
    assign isLtS = ($signed(i_rs1Data) < $signed(i_rs2Data));
    assign isLtU = (i_rs1Data < i_rs2Data);

    always_comb begin
        case (funct3)
            3'b000:  brTaken = isEq;        // BEQ
            3'b001:  brTaken = !isEq;       // BNE
            3'b100:  brTaken = isLtS;       // BLT
            3'b101:  brTaken = !isLtS;      // BGE
            3'b110:  brTaken = isLtU;       // BLTU
            3'b111:  brTaken = !isLtU;      // BGEU
            default: brTaken = 1'b0;        // Reserved codes fall through
        endcase
    end

    // Shared by OP and OP-IMM
    always_comb begin
        arithValid = 1'b1;
        case (funct3)
            3'b000: begin
                // funct7 bits are immediate bits in OP-IMM, so SUB only for OP
                if (i_inst.r.opcode == rvPkg::OpcOp && funct7[5])
                    arithOp = rvPkg::AluSub;
                else
                    arithOp = rvPkg::AluAdd;
            end
            3'b010:  arithOp = rvPkg::AluSlt;
            3'b011:  arithOp = rvPkg::AluSltu;
            3'b100:  arithOp = rvPkg::AluXor;
            3'b110:  arithOp = rvPkg::AluOr;
            3'b111:  arithOp = rvPkg::AluAnd;
            default: begin
                arithOp    = rvPkg::AluAdd;     // Shifts, not implemented
                arithValid = 1'b0;
            end
        endcase
    end

    always_comb begin
        // NOP defaults
        o_aluOp       = rvPkg::AluAdd;
        o_opBSel      = 1'b0;
        o_wbSel       = rvPkg::WbAlu;
        o_regWrEnable = 1'b0;
        o_memWrEnable = 1'b0;
        o_pcSel       = rvPkg::PcSeq;
        case (i_inst.r.opcode)
            rvPkg::OpcOp: begin
                o_aluOp       = arithOp;
                o_regWrEnable = arithValid;
            end
            rvPkg::OpcOpImm: begin
                o_aluOp       = arithOp;
                o_opBSel      = 1'b1;
                o_regWrEnable = arithValid;
            end
            rvPkg::OpcLui: begin
                o_aluOp       = rvPkg::AluPassB;    // Immediate straight through
                o_opBSel      = 1'b1;
                o_regWrEnable = 1'b1;
            end
            rvPkg::OpcLoad: begin
                o_opBSel      = 1'b1;               // Address rs1+imm
                o_wbSel       = rvPkg::WbMem;
                o_regWrEnable = (funct3 == `RV_F3_WORD);   // LW only
            end
            rvPkg::OpcStore: begin
                o_opBSel      = 1'b1;
                o_memWrEnable = (funct3 == `RV_F3_WORD);   // SW only
            end
            rvPkg::OpcBranch: begin
                o_pcSel = brTaken ? rvPkg::PcRel : rvPkg::PcSeq;
            end
            rvPkg::OpcJal: begin
                o_wbSel       = rvPkg::WbPcPlus4;   // Link value
                o_regWrEnable = 1'b1;
                o_pcSel       = rvPkg::PcRel;
            end
            rvPkg::OpcJalr: begin
                o_wbSel       = rvPkg::WbPcPlus4;
                o_regWrEnable = 1'b1;
                o_pcSel       = rvPkg::PcJalr;
            end
            default: ;                              // Unknown, keep NOP
        endcase
    end

endmodule

//--- design/instDecoder.sv
// Combinational field extract; unknown opcodes give a zero immediate, U format assumes 32 bits
`include "rvDefs_defs.svh"

module instDecoder (
    input  rvPkg::instU              i_inst,    // Current instruction
    output logic [`RV_REG_AW-1:0]    o_rs1,     // Source register 1
    output logic [`RV_REG_AW-1:0]    o_rs2,     // Source register 2
    output logic [`RV_REG_AW-1:0]    o_rd,      // Destination register
    output logic [`RV_XLEN-1:0]      o_imm      // Sign-extended immediate
);

    // Same bit positions in every format
    assign o_rs1 = i_inst.r.rs1;
    assign o_rs2 = i_inst.r.rs2;
    assign o_rd  = i_inst.r.rd;

    always_comb begin
        case (i_inst.r.opcode)
            rvPkg::OpcOpImm,
            rvPkg::OpcLoad,
            rvPkg::OpcJalr: begin                       // I format
                o_imm = {{(`RV_XLEN-12){i_inst.i.imm[11]}}, i_inst.i.imm};
            end
            rvPkg::OpcStore: begin                      // S format, split field
                o_imm = {{(`RV_XLEN-12){i_inst.s.immHi[6]}},
                         i_inst.s.immHi, i_inst.s.immLo};
            end
            rvPkg::OpcBranch: begin
                // B format, scattered, bit 0 always zero
                o_imm = {{(`RV_XLEN-13){i_inst.b.imm12}}, i_inst.b.imm12,
                         i_inst.b.imm11, i_inst.b.immHi, i_inst.b.immLo, 1'b0};
            end
            rvPkg::OpcLui: begin                        // Upper 20 bits, low 12 cleared
                o_imm = {i_inst.u.imm, 12'h000};
            end
            rvPkg::OpcJal: begin
                // J format, 21-bit signed offset
                o_imm = {{(`RV_XLEN-21){i_inst.j.imm20}}, i_inst.j.imm20,
                         i_inst.j.immHi, i_inst.j.imm11, i_inst.j.immLo, 1'b0};
            end
            default: begin
                o_imm = '0;                             // R format and unknown
            end
        endcase
    end

endmodule

//--- design/rvPkg.sv
// Types for the RV32I subset only; enum values follow the base ISA encodings
package rvPkg;

    // Major opcodes, bits 6:0 of every instruction
    typedef enum logic [6:0] {
        OpcLoad   = 7'b0000011,
        OpcStore  = 7'b0100011,
        OpcOp     = 7'b0110011,
        OpcOpImm  = 7'b0010011,
        OpcLui    = 7'b0110111,
        OpcBranch = 7'b1100011,
        OpcJal    = 7'b1101111,
        OpcJalr   = 7'b1100111
    } opcodeE;

    // ALU functions, internal encoding
    typedef enum logic [2:0] {
        AluAdd, AluSub, AluAnd, AluOr, AluXor, AluSlt, AluSltu, AluPassB
    } aluOpE;

    // Writeback source
    typedef enum logic [1:0] {
        WbAlu, WbMem, WbPcPlus4
    } wbSelE;

    // Next PC choice
    typedef enum logic [1:0] {
        PcSeq,      // PC+4
        PcRel,      // PC+imm, taken branch or JAL
        PcJalr      // rs1+imm, bit 0 cleared
    } pcSelE;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcodeE     opcode;
    } instRT;

    typedef struct packed {
        logic [11:0] imm;           // imm[11:0]
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcodeE      opcode;
    } instIT;

    typedef struct packed {
        logic [6:0] immHi;          // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;          // imm[4:0]
        opcodeE     opcode;
    } instST;

    typedef struct packed {
        logic       imm12;
        logic [5:0] immHi;          // imm[10:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] immLo;          // imm[4:1]
        logic       imm11;
        opcodeE     opcode;
    } instBT;

    typedef struct packed {
        logic [19:0] imm;           // imm[31:12]
        logic [4:0]  rd;
        opcodeE      opcode;
    } instUT;

    typedef struct packed {
        logic       imm20;
        logic [9:0] immLo;          // imm[10:1]
        logic       imm11;
        logic [7:0] immHi;          // imm[19:12]
        logic [4:0] rd;
        opcodeE     opcode;
    } instJT;

    // One word, six views
    typedef union packed {
        instRT r;
        instIT i;
        instST s;
        instBT b;
        instUT u;
        instJT j;
    } instU;

endpackage

//--- include/rvDefs_defs.svh
// Core sizes for RV32I only; the instruction layout assumes a 32-bit word, keep RV_XLEN at 32
`ifndef RVDEFS_DEFS_SVH
`define RVDEFS_DEFS_SVH

// Data and address width
// Also the width of the PC and of every register
`define RV_XLEN 32

// Register address width, 32 architectural registers
`define RV_REG_AW 5

// PC loaded while reset is held
// Must stay word aligned, the core has no misaligned fetch check
`define RV_RESET_PC 32'h0000_0000

// Word size in bytes, used for the sequential PC step
`define RV_WORD_BYTES 4

// Function code of LW and SW, the only access size kept
`define RV_F3_WORD 3'b010

`endif
